// ==== verilog/vst_defines.svh ====
//////////////////////////////////////////////////////////////////////
// Sizing macros for the vector store unit
// Queue depth is fixed at 4 by the two-bit queue pointer type
// The W beat is always NR_LANES x 8 bytes wide
//////////////////////////////////////////////////////////////////////
`ifndef VST_DEFINES_SVH
`define VST_DEFINES_SVH

// Lanes feeding one 64-bit operand each per beat
`define VST_NR_LANES 4

// In-flight store instructions
`define VST_QUEUE_DEPTH 4

// Vector length field, max vl of 64 elements
`define VST_VL_W 7

// Sequencer instruction id
`define VST_ID_W 3

`endif

// ==== verilog/vst_insn_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction-side types of the vector store unit
// Element width encodes bytes per element as a power of two
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "vst_defines.svh"

package vst_insn_pkg;

  // Id handed back to the sequencer on completion
  typedef logic [`VST_ID_W-1:0] insn_id_t;

  // Vector length in elements
  typedef logic [`VST_VL_W-1:0] vl_t;

  // Remaining bytes, up to vl x 8
  typedef logic [`VST_VL_W+2:0] byte_cnt_t;

  // Bytes per element is 1 << value
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } elem_width_e;

  // Queue index and occupancy
  typedef logic [1:0] queue_ptr_t;
  typedef logic [2:0] queue_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/vst_mem_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Memory write side types of the vector store unit
// W data and strobe are lane-major, lane 0 in the low bits
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "vst_defines.svh"

package vst_mem_pkg;

  // One lane operand and its byte mask
  typedef logic [63:0] lane_word_t;
  typedef logic [7:0]  lane_strb_t;

  // Full W beat, one lane word set wide
  typedef logic [`VST_NR_LANES*64-1:0] w_data_t;
  typedef logic [`VST_NR_LANES*8-1:0]  w_strb_t;

  // Beats in a burst minus one
  typedef logic [7:0] burst_len_t;

endpackage

`default_nettype wire

// ==== verilog/operand_skid_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// One-entry fall-through buffer for a lane operand
// Input sees ready low while a stalled word is held
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module operand_skid_buffer import vst_mem_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Lane side
  input  lane_word_t data_i,
  input  logic       valid_i,
  output logic       ready_o,
  // Store unit side
  output lane_word_t data_o,
  output logic       valid_o,
  input  logic       ready_i
);

  logic       full_q;
  lane_word_t data_q;

  // Empty buffer passes the lane straight through
  assign ready_o = !full_q;
  assign valid_o = full_q || valid_i;
  assign data_o  = full_q ? data_q : data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Held word leaves on the consumer handshake
      full_q <= !ready_i;
    end else begin
      full_q <= valid_i && !ready_i;
    end
  end

  // Capture the word when the consumer stalls
  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

  // Offered word stays put until taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("operand changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/vst_insn_queue.sv ====
//////////////////////////////////////////////////////////////////////
// Store instruction queue with accept, issue and commit phases
// Each store gets exactly one B response, B errors are ignored
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "vst_defines.svh"

module vst_insn_queue import vst_insn_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Sequencer request
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  insn_id_t    req_id_i,
  input  vl_t         req_vl_i,
  input  elem_width_e req_ew_i,
  input  logic        req_vm_i,
  // Issue side, towards the beat packer
  output logic        issue_valid_o,
  output vl_t         issue_vl_o,
  output elem_width_e issue_ew_o,
  output logic        issue_vm_o,
  input  logic        issue_done_i,
  // Commit side
  input  logic        b_valid_i,
  output logic        b_ready_o,
  output logic        store_complete_o,
  output logic        done_valid_o,
  output insn_id_t    done_id_o,
  output logic        store_pending_o
);

  localparam int unsigned QDepth = `VST_QUEUE_DEPTH;

  // Instruction storage
  insn_id_t    id_q [QDepth];
  vl_t         vl_q [QDepth];
  elem_width_e ew_q [QDepth];
  logic        vm_q [QDepth];

  // One pointer per phase
  queue_ptr_t accept_pnt_q;
  queue_ptr_t issue_pnt_q;
  queue_ptr_t commit_pnt_q;

  // Instructions still to issue, and all not yet committed
  queue_cnt_t issue_cnt_q;
  queue_cnt_t commit_cnt_q;

  logic     accept;
  logic     b_fire;
  logic     done_valid_q;
  insn_id_t done_id_q;

  assign req_ready_o = (commit_cnt_q != queue_cnt_t'(QDepth));
  assign accept      = req_valid_i && req_ready_o;

  // Oldest instruction not fully issued
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_vl_o    = vl_q[issue_pnt_q];
  assign issue_ew_o    = ew_q[issue_pnt_q];
  assign issue_vm_o    = vm_q[issue_pnt_q];

  // Commit only what has finished issuing
  assign b_ready_o        = (commit_cnt_q != issue_cnt_q);
  assign b_fire           = b_valid_i && b_ready_o;
  assign store_complete_o = b_fire;
  assign store_pending_o  = (commit_cnt_q != '0);

  assign done_valid_o = done_valid_q;
  assign done_id_o    = done_id_q;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q] <= req_id_i;
      vl_q[accept_pnt_q] <= req_vl_i;
      ew_q[accept_pnt_q] <= req_ew_i;
      vm_q[accept_pnt_q] <= req_vm_i;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Pointers and counters

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_valid_q <= 1'b0;
    end else begin
      // Pointers wrap with the two-bit index
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (b_fire) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + queue_cnt_t'(accept) - queue_cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + queue_cnt_t'(accept) - queue_cnt_t'(b_fire);
      // Done goes out one cycle after the B handshake
      done_valid_q <= b_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_fire) begin
      done_id_q <= id_q[commit_pnt_q];
    end
  end

  // Accepted entry is visible next cycle and stays within depth
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> (commit_cnt_q != '0) && (commit_cnt_q <= queue_cnt_t'(QDepth)))
    else $error("request accepted into a full queue");

  // B consumes only instructions past the issue phase
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_fire |-> (commit_cnt_q > issue_cnt_q))
    else $error("B response with nothing awaiting commit");

endmodule

`default_nettype wire

// ==== verilog/vst_beat_packer.sv ====
//////////////////////////////////////////////////////////////////////
// Builds W beats from lane words in sequential memory order
// Bursts are aligned, one beat consumes one full lane word set
// Mask bits are taken at the same lane and lane byte as the data
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "vst_defines.svh"

module vst_beat_packer import vst_insn_pkg::*; import vst_mem_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Issuing instruction
  input  logic                           issue_valid_i,
  input  vl_t                            issue_vl_i,
  input  elem_width_e                    issue_ew_i,
  input  logic                           issue_vm_i,
  output logic                           issue_done_o,
  // Lane operands from the buffers
  input  lane_word_t [`VST_NR_LANES-1:0] lane_data_i,
  input  logic       [`VST_NR_LANES-1:0] lane_valid_i,
  output logic                           lane_ready_o,
  // Mask operand
  input  w_strb_t                        mask_i,
  input  logic                           mask_valid_i,
  output logic                           mask_ready_o,
  // Burst request from the address generator
  input  burst_len_t                     burst_len_i,
  input  logic                           burst_valid_i,
  output logic                           burst_ready_o,
  // W channel
  output w_data_t                        w_data_o,
  output w_strb_t                        w_strb_o,
  output logic                           w_last_o,
  output logic                           w_valid_o,
  input  logic                           w_ready_i
);

  localparam int unsigned NrLanes   = `VST_NR_LANES;
  localparam int unsigned BeatBytes = NrLanes * 8;

  // Remaining bytes, valid once loaded
  byte_cnt_t  cnt_q;
  logic       loaded_q;
  byte_cnt_t  cnt_eff;
  byte_cnt_t  cnt_next;
  // Beat index within the current burst
  burst_len_t beat_q;
  logic       burst_last;
  logic       w_fire;

  // Fresh instruction starts at vl x EW bytes
  assign cnt_eff  = loaded_q ? cnt_q : (byte_cnt_t'(issue_vl_i) << issue_ew_i);
  // Floor at zero on the tail beat
  assign cnt_next = (cnt_eff > byte_cnt_t'(BeatBytes)) ?
                    (cnt_eff - byte_cnt_t'(BeatBytes)) : '0;

  ///////////////////////////////////////////////////////////////////////
  // Handshakes

  // Beat offered as soon as every source is there
  assign w_valid_o = issue_valid_i && (&lane_valid_i) &&
                     (issue_vm_i || mask_valid_i) && burst_valid_i;
  assign w_fire    = w_valid_o && w_ready_i;

  assign lane_ready_o = w_fire;
  // Mask channel idle for unmasked stores
  assign mask_ready_o = w_fire && !issue_vm_i;

  assign burst_last    = (beat_q == burst_len_i);
  assign w_last_o      = w_valid_o && burst_last;
  assign burst_ready_o = w_fire && burst_last;

  assign issue_done_o = w_fire && (cnt_next == '0);

  ///////////////////////////////////////////////////////////////////////
  // Lane to memory byte un-shuffle

  always_comb begin : p_unshuffle
    int unsigned ebytes;
    int unsigned elem;
    int unsigned lane;
    int unsigned lbyte;
    w_data_o = '0;
    w_strb_o = '0;
    ebytes   = 1 << issue_ew_i;
    for (int unsigned i = 0; i < BeatBytes; i++) begin
      // Element within this beat, elements interleave over lanes
      elem  = i >> issue_ew_i;
      lane  = elem % NrLanes;
      lbyte = ((elem / NrLanes) << issue_ew_i) + (i & (ebytes - 1));
      // Bytes past the vector tail stay zero
      if (i < cnt_eff) begin
        w_data_o[8*i +: 8] = lane_data_i[lane][8*lbyte +: 8];
        w_strb_o[i]        = issue_vm_i || mask_i[8*lane + lbyte];
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Counters

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      loaded_q <= 1'b0;
      beat_q   <= '0;
    end else if (w_fire) begin
      cnt_q    <= cnt_next;
      // Drop the load flag so the next instruction reloads
      loaded_q <= (cnt_next != '0);
      if (burst_last) begin
        beat_q <= '0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // Lanes acknowledged together and only while bytes remain
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lane_ready_o |-> (&lane_valid_i) && (cnt_eff != '0))
    else $error("lane acknowledged without a full operand set");

endmodule

`default_nettype wire

// ==== verilog/vst_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Vector store unit top, lane buffers around queue and beat packer
// Address generation lives outside, bursts arrive aligned
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "vst_defines.svh"

module vst_unit import vst_insn_pkg::*; import vst_mem_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Sequencer request
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  insn_id_t                       req_id_i,
  input  vl_t                            req_vl_i,
  input  elem_width_e                    req_ew_i,
  input  logic                           req_vm_i,
  // Lane operands
  input  lane_word_t [`VST_NR_LANES-1:0] operand_i,
  input  logic       [`VST_NR_LANES-1:0] operand_valid_i,
  output logic       [`VST_NR_LANES-1:0] operand_ready_o,
  // Mask operand
  input  w_strb_t                        mask_i,
  input  logic                           mask_valid_i,
  output logic                           mask_ready_o,
  // Address generator bursts
  input  burst_len_t                     burst_len_i,
  input  logic                           burst_valid_i,
  output logic                           burst_ready_o,
  // W channel
  output w_data_t                        w_data_o,
  output w_strb_t                        w_strb_o,
  output logic                           w_last_o,
  output logic                           w_valid_o,
  input  logic                           w_ready_i,
  // B channel
  input  logic                           b_valid_i,
  output logic                           b_ready_o,
  // Status
  output logic                           store_pending_o,
  output logic                           store_complete_o,
  output logic                           done_valid_o,
  output insn_id_t                       done_id_o
);

  localparam int unsigned NrLanes = `VST_NR_LANES;

  lane_word_t [NrLanes-1:0] lane_data;
  logic       [NrLanes-1:0] lane_valid;
  logic                     lane_ready;

  logic        issue_valid;
  vl_t         issue_vl;
  elem_width_e issue_ew;
  logic        issue_vm;
  logic        issue_done;

  ///////////////////////////////////////////////////////////////////////
  // Lane operand buffers, all drained by one shared ready

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lane_buf
    operand_skid_buffer i_lane_buf (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .data_i (operand_i[lane]),
      .valid_i(operand_valid_i[lane]),
      .ready_o(operand_ready_o[lane]),
      .data_o (lane_data[lane]),
      .valid_o(lane_valid[lane]),
      .ready_i(lane_ready)
    );
  end

  ///////////////////////////////////////////////////////////////////////
  // Instruction bookkeeping

  vst_insn_queue i_insn_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_id_i        (req_id_i),
    .req_vl_i        (req_vl_i),
    .req_ew_i        (req_ew_i),
    .req_vm_i        (req_vm_i),
    .issue_valid_o   (issue_valid),
    .issue_vl_o      (issue_vl),
    .issue_ew_o      (issue_ew),
    .issue_vm_o      (issue_vm),
    .issue_done_i    (issue_done),
    .b_valid_i       (b_valid_i),
    .b_ready_o       (b_ready_o),
    .store_complete_o(store_complete_o),
    .done_valid_o    (done_valid_o),
    .done_id_o       (done_id_o),
    .store_pending_o (store_pending_o)
  );

  ///////////////////////////////////////////////////////////////////////
  // Beat building datapath

  vst_beat_packer i_beat_packer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_valid_i(issue_valid),
    .issue_vl_i   (issue_vl),
    .issue_ew_i   (issue_ew),
    .issue_vm_i   (issue_vm),
    .issue_done_o (issue_done),
    .lane_data_i  (lane_data),
    .lane_valid_i (lane_valid),
    .lane_ready_o (lane_ready),
    .mask_i       (mask_i),
    .mask_valid_i (mask_valid_i),
    .mask_ready_o (mask_ready_o),
    .burst_len_i  (burst_len_i),
    .burst_valid_i(burst_valid_i),
    .burst_ready_o(burst_ready_o),
    .w_data_o     (w_data_o),
    .w_strb_o     (w_strb_o),
    .w_last_o     (w_last_o),
    .w_valid_o    (w_valid_o),
    .w_ready_i    (w_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb/tb_vst_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Random store traffic against a byte-level model of the W beats
// Bursts never cross a store, one B per store after its last beat
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "vst_defines.svh"

module tb_vst_unit import vst_insn_pkg::*; import vst_mem_pkg::*; ();

  localparam int NrLanes   = `VST_NR_LANES;
  localparam int BeatBytes = NrLanes * 8;
  localparam int NumInsn   = 40;
  // Up to 64 elements of 8 bytes, 16 beats per store
  localparam int MaxBeats  = NumInsn * 16;
  localparam int WatchdogCycles = NumInsn * 200;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_valid_i;
  logic                     req_ready_o;
  insn_id_t                 req_id_i;
  vl_t                      req_vl_i;
  elem_width_e              req_ew_i;
  logic                     req_vm_i;
  lane_word_t [NrLanes-1:0] operand_i;
  logic       [NrLanes-1:0] operand_valid_i;
  logic       [NrLanes-1:0] operand_ready_o;
  w_strb_t                  mask_i;
  logic                     mask_valid_i;
  logic                     mask_ready_o;
  burst_len_t               burst_len_i;
  logic                     burst_valid_i;
  logic                     burst_ready_o;
  w_data_t                  w_data_o;
  w_strb_t                  w_strb_o;
  logic                     w_last_o;
  logic                     w_valid_o;
  logic                     w_ready_i;
  logic                     b_valid_i;
  logic                     b_ready_o;
  logic                     store_pending_o;
  logic                     store_complete_o;
  logic                     done_valid_o;
  insn_id_t                 done_id_o;

  integer seed;

  // Store list and the bursts it is split into
  insn_id_t    ins_id    [NumInsn];
  vl_t         ins_vl    [NumInsn];
  elem_width_e ins_ew    [NumInsn];
  logic        ins_vm    [NumInsn];
  int          ins_beats [NumInsn];
  int          burst_list[$];
  int          total_beats = 0;
  int          total_mask_beats = 0;

  // Words and masks in the order the sources handed them over
  lane_word_t lane_hist [NrLanes][MaxBeats];
  w_strb_t    mask_hist [MaxBeats];
  int         lane_sent [NrLanes];
  // Lane buffer holds a word that met a stalled beat
  logic       lane_full [NrLanes];
  int         mask_sent = 0;
  int         mask_used = 0;
  int         src_burst = 0;

  // Model progress
  int accepted = 0;
  int issued = 0;
  int committed = 0;
  int beat_insn = 0;
  int beat_k = 0;
  int beat_total = 0;
  int mdl_burst = 0;
  int burst_pos = 0;
  logic     done_exp = 1'b0;
  insn_id_t done_id_exp;
  logic     stalled = 1'b0;
  w_data_t  held_data;
  w_strb_t  held_strb;

  vst_unit UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic expect_equal(input logic [255:0] got, input logic [255:0] exp,
                              input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // Beat k of store n, byte s maps to element s / EW in lane (s / EW) mod lanes
  task automatic expected_beat(input int n, input int k, input int widx, input int midx,
                               output w_data_t d, output w_strb_t s);
    int ew_bytes;
    int nbytes;
    int sb;
    int e;
    int lane;
    int g;
    d = '0;
    s = '0;
    ew_bytes = 1 << ins_ew[n];
    nbytes   = int'(ins_vl[n]) * ew_bytes;
    for (int i = 0; i < BeatBytes; i++) begin
      sb = k * BeatBytes + i;
      if (sb < nbytes) begin
        e    = sb / ew_bytes;
        lane = e % NrLanes;
        // Lane byte offset, the word index always equals k
        g    = ((e / NrLanes) * ew_bytes + sb % ew_bytes) % 8;
        d[8*i +: 8] = lane_hist[lane][widx][8*g +: 8];
        s[i] = ins_vm[n] ? 1'b1 : mask_hist[midx][8*lane + g];
      end
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Reset, store list and end of run

  initial begin
    seed = 32'hafb9;
    rst_ni = 1'b0;
    req_valid_i = 1'b0;
    req_id_i = '0;
    req_vl_i = '0;
    req_ew_i = EW8;
    req_vm_i = 1'b0;
    operand_i = '0;
    operand_valid_i = '0;
    mask_i = '0;
    mask_valid_i = 1'b0;
    burst_len_i = '0;
    burst_valid_i = 1'b0;
    w_ready_i = 1'b0;
    b_valid_i = 1'b0;
    for (int l = 0; l < NrLanes; l++) begin
      lane_sent[l] = 0;
      lane_full[l] = 1'b0;
    end
    for (int n = 0; n < NumInsn; n++) begin
      int rem;
      int len;
      ins_id[n] = insn_id_t'(rand_below(8));
      ins_vl[n] = vl_t'(1 + rand_below(64));
      ins_ew[n] = elem_width_e'(rand_below(4));
      ins_vm[n] = (rand_below(2) == 1);
      ins_beats[n] = (int'(ins_vl[n]) * (1 << ins_ew[n]) + BeatBytes - 1) / BeatBytes;
      total_beats += ins_beats[n];
      if (!ins_vm[n]) begin
        total_mask_beats += ins_beats[n];
      end
      // Random bursts of one to four beats, stored as beats minus one
      rem = ins_beats[n];
      while (rem > 0) begin
        len = 1 + rand_below(rem < 4 ? rem : 4);
        burst_list.push_back(len - 1);
        rem -= len;
      end
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (committed < NumInsn) begin
      @(posedge clk_i);
    end
    // Let the last done pulse get checked
    repeat (2) @(posedge clk_i);
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: stores did not complete within %0d cycles", WatchdogCycles);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  ///////////////////////////////////////////////////////////////////////
  // Checks on the sampled edge, then the next source values

  always @(posedge clk_i) begin : model_and_drive
    logic    req_fire;
    logic    w_fire;
    logic    b_fire;
    logic    lanes_ready;
    logic    masked;
    logic    exp_valid;
    logic    exp_last;
    w_data_t exp_data;
    w_strb_t exp_strb;
    if (rst_ni) begin
      // Beat the model expects from the sources it drove
      lanes_ready = 1'b1;
      for (int l = 0; l < NrLanes; l++) begin
        lanes_ready = lanes_ready && (lane_full[l] || operand_valid_i[l]);
      end
      masked    = 1'b0;
      exp_valid = 1'b0;
      if (accepted > issued) begin
        masked    = !ins_vm[beat_insn];
        exp_valid = lanes_ready && burst_valid_i && (!masked || mask_valid_i);
      end
      req_fire = req_valid_i && (accepted - committed < 4);
      w_fire   = exp_valid && w_ready_i;
      b_fire   = b_valid_i && (issued != committed);

      // Status against model occupancy
      expect_equal(256'(req_ready_o), 256'(accepted - committed < 4), "req_ready_o");
      expect_equal(256'(store_pending_o), 256'(accepted != committed), "store_pending_o");
      expect_equal(256'(b_ready_o), 256'(issued != committed), "b_ready_o");
      expect_equal(256'(store_complete_o), 256'(b_fire), "store_complete_o");
      expect_equal(256'(done_valid_o), 256'(done_exp), "done_valid_o");
      if (done_exp) begin
        expect_equal(256'(done_id_o), 256'(done_id_exp), "done_id_o");
      end
      done_exp = b_fire;
      if (b_fire) begin
        done_id_exp = ins_id[committed];
      end

      // Operand side handshakes
      expect_equal(256'(w_valid_o), 256'(exp_valid), "w_valid_o");
      expect_equal(256'(mask_ready_o), 256'(w_fire && masked), "mask_ready_o");
      for (int l = 0; l < NrLanes; l++) begin
        expect_equal(256'(operand_ready_o[l]), 256'(!lane_full[l]), "operand_ready_o");
      end

      // Stalled beat must not move
      if (stalled) begin
        expect_equal(256'(w_valid_o), 256'(1'b1), "w_valid_o while stalled");
        expect_equal(w_data_o, held_data, "w_data_o while stalled");
        expect_equal(256'(w_strb_o), 256'(held_strb), "w_strb_o while stalled");
      end
      stalled   = w_valid_o && !w_ready_i;
      held_data = w_data_o;
      held_strb = w_strb_o;

      // Record handovers before a fall-through beat uses them
      for (int l = 0; l < NrLanes; l++) begin
        if (operand_valid_i[l] && operand_ready_o[l]) begin
          lane_hist[l][lane_sent[l]] = operand_i[l];
          lane_sent[l]++;
        end
        // Word arriving on a stalled beat waits in the buffer
        lane_full[l] = lane_full[l] ? !w_fire : (operand_valid_i[l] && !w_fire);
      end
      if (mask_valid_i && mask_ready_o) begin
        mask_hist[mask_sent] = mask_i;
        mask_sent++;
      end

      exp_last = exp_valid && (mdl_burst < burst_list.size()) &&
                 (burst_pos == burst_list[mdl_burst]);
      expect_equal(256'(w_last_o), 256'(exp_last), "w_last_o");
      if (w_fire) begin
        expected_beat(beat_insn, beat_k, beat_total, mask_used, exp_data, exp_strb);
        expect_equal(w_data_o, exp_data, "w_data_o");
        expect_equal(256'(w_strb_o), 256'(exp_strb), "w_strb_o");
        if (!ins_vm[beat_insn]) begin
          mask_used++;
        end
        beat_total++;
        beat_k++;
        if (exp_last) begin
          mdl_burst++;
          burst_pos = 0;
        end else begin
          burst_pos++;
        end
        if (beat_k == ins_beats[beat_insn]) begin
          beat_k = 0;
          beat_insn++;
          issued++;
        end
      end
      expect_equal(256'(burst_ready_o), 256'(exp_last && w_ready_i), "burst_ready_o");
      if (req_fire) begin
        accepted++;
      end
      if (b_fire) begin
        committed++;
      end

      // Sequencer
      if (!req_valid_i || req_ready_o) begin
        req_valid_i <= (accepted < NumInsn) && (rand_below(4) != 0);
        if (accepted < NumInsn) begin
          req_id_i <= ins_id[accepted];
          req_vl_i <= ins_vl[accepted];
          req_ew_i <= ins_ew[accepted];
          req_vm_i <= ins_vm[accepted];
        end
      end
      // Lanes, each free to change only when idle or just taken
      for (int l = 0; l < NrLanes; l++) begin
        if (!operand_valid_i[l] || operand_ready_o[l]) begin
          operand_valid_i[l] <= (lane_sent[l] < total_beats) && (rand_below(4) != 0);
          operand_i[l] <= {$random(seed), $random(seed)};
        end
      end
      // Mask source
      if (!mask_valid_i || mask_ready_o) begin
        mask_valid_i <= (mask_sent < total_mask_beats) && (rand_below(4) != 0);
        mask_i <= w_strb_t'($random(seed));
      end
      // Address generator
      if (burst_valid_i && burst_ready_o) begin
        src_burst++;
      end
      if (!burst_valid_i || burst_ready_o) begin
        burst_valid_i <= (src_burst < burst_list.size()) && (rand_below(3) != 0);
        if (src_burst < burst_list.size()) begin
          burst_len_i <= burst_len_t'(burst_list[src_burst]);
        end
      end
      // B after the last beat of a store, random delay
      if (!b_valid_i || b_ready_o) begin
        b_valid_i <= (issued > committed) && (rand_below(3) == 0);
      end
      w_ready_i <= (rand_below(4) != 0);
    end
  end

endmodule

`default_nettype wire

// ==== vst_unit.f ====
+incdir+verilog
verilog/vst_insn_pkg.sv
verilog/vst_mem_pkg.sv
verilog/operand_skid_buffer.sv
verilog/vst_insn_queue.sv
verilog/vst_beat_packer.sv
verilog/vst_unit.sv
tb/tb_vst_unit.sv

// ==== Makefile ====
# Verilator flow for the vector store unit
TOP := tb_vst_unit

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level with all warnings
lint:
	verilator --lint-only -Wall --timing -f vst_unit.f --top-module vst_unit

# Build and run, the exit status carries pass or fail
sim:
	verilator --binary --timing --assert -Wno-fatal -f vst_unit.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
